/* files.f */
rtl/rv_fetch_pkg.sv
rtl/rvc_expander.sv
rtl/instr_align.sv
rtl/pc_gen.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
dv/fetch_sva.sv
dv/tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --assert -Wno-fatal
SRCS      := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_fetch.sv */
module tb_fetch import rv_fetch_pkg::*; ;

    localparam pc_t RESET_PC  = pc_t'(32'h4000_0000 >> 1);
    localparam int  PERIOD    = 8;
    localparam int  N_PROG    = 600;   // instructions in the program
    localparam int  N_ALIGNED = 40;    // leading 32-bit only section
    localparam int  N_DELIV   = 400;   // deliveries to check
    localparam int  MAX_CPI   = 16;

    logic  clk, rst, mem_wait, stall, flush, redir;
    pc_t   mem_addr, redir_pc, dec_pc, dec_pc_next, mem_off;
    xlen_t mem_data, dec_instr;
    logic  dec_valid;

    parcel_t     prog [0:2047];        // program as halfwords
    int          starts [0:N_PROG-1];  // parcel index of each instruction
    int unsigned seed = 32'he5af;
    int          delivered = 0;
    int          ptr = 0;              // expected parcel index
    int          redir_idx = 0;

    fetch_top #(.RESET_PC(RESET_PC)) dut (
        .clk_i(clk), .rst_i(rst), .mem_addr_o(mem_addr), .mem_data_i(mem_data),
        .mem_wait_i(mem_wait), .stall_i(stall), .flush_i(flush),
        .redirect_valid_i(redir), .redirect_pc_i(redir_pc), .dec_instr_o(dec_instr),
        .dec_pc_o(dec_pc), .dec_pc_next_o(dec_pc_next), .dec_valid_o(dec_valid)
    );

    // memory answers in the same cycle
    assign mem_off  = mem_addr - RESET_PC;
    assign mem_data = {prog[{mem_off[10:1], 1'b1}], prog[{mem_off[10:1], 1'b0}]};

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // random compressed parcel from a few supported formats
    function automatic parcel_t make_rvc(int unsigned r);
        parcel_t c;
        c = parcel_t'(r >> 5);
        case ((r >> 24) % 8)
            0: c = {3'b000, c[12:2], 2'b01};               // addi
            1: c = {3'b010, c[12:2], 2'b01};               // li
            2: c = {3'b010, c[12:2], 2'b00};               // lw
            3: c = {3'b110, c[12:2], 2'b00};               // sw
            4: c = {3'b000, 1'b0, c[11:2], 2'b10};         // slli with shamt below 32
            5: c = {3'b100, 1'b0, c[11:3], 1'b1, 2'b10};   // mv with nonzero rs2
            6: c = {3'b100, 1'b1, c[11:3], 1'b1, 2'b10};   // add
            default: c = {3'b101, c[12:2], 2'b01};         // j
        endcase
        return c;
    endfunction

    function automatic xlen_t expand_ref(parcel_t c);
        logic [11:0] off;
        logic [20:0] j;
        logic [4:0]  rd, rs2, rdp, rsp;
        rd  = c[11:7];
        rs2 = c[6:2];
        rdp = {2'b01, c[4:2]};
        rsp = {2'b01, c[9:7]};
        case ({c[15:13], c[1:0]})
            5'b000_01: return {{7{c[12]}}, c[6:2], rd, 3'b000, rd, OPC_OP_IMM};
            5'b010_01: return {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, OPC_OP_IMM};
            5'b010_00: return {5'd0, c[5], c[12:10], c[6], 2'b00, rsp, 3'b010, rdp, OPC_LOAD};
            5'b110_00: return {5'd0, c[5], c[12], rdp, rsp, 3'b010, c[11:10], c[6], 2'b00,
                               OPC_STORE};
            5'b000_10: return {7'd0, rs2, rd, 3'b001, rd, OPC_OP_IMM};
            5'b100_10: return c[12] ? {7'd0, rs2, rd, 3'b000, rd, OPC_OP}
                                    : {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
            5'b101_01: begin
                off = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
                j   = {{9{off[11]}}, off};
                return {j[20], j[10:1], j[11], j[19:12], 5'd0, OPC_JAL};
            end
            default: return INSTR_BUBBLE;
        endcase
    endfunction

    function automatic int instr_len(int p);
        return (prog[p][1:0] == 2'b11) ? 2 : 1;
    endfunction

    function automatic xlen_t ref_instr(int p);
        return instr_len(p) == 2 ? {prog[p+1], prog[p]} : expand_ref(prog[p]);
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(PERIOD * (N_DELIV * MAX_CPI + 20));
        $display("timeout: the fetch stage stopped delivering instructions");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // compare each delivery with the reference walk
    initial begin
        logic flush_pending;
        flush_pending = 1'b0;
        forever begin
            @(posedge clk);
            if (flush_pending) begin  // slot loaded by the flush must be empty
                check("dec_valid_o", 32'(dec_valid), 32'd0);
                check("dec_instr_o", dec_instr, INSTR_BUBBLE);
                flush_pending = 1'b0;
            end
            if (!rst && dec_valid && !(stall || mem_wait)) begin
                check("dec_instr_o", dec_instr, ref_instr(ptr));
                check("dec_pc_o", dec_pc, RESET_PC + pc_t'(ptr));
                check("dec_pc_next_o", dec_pc_next, RESET_PC + pc_t'(ptr + instr_len(ptr)));
                ptr = ptr + instr_len(ptr);
                delivered++;
            end
            if (!rst && flush && !(stall || mem_wait)) flush_pending = 1'b1;
            if (!rst && redir && !(stall || mem_wait)) ptr = redir_idx;  // restart at target
        end
    end

    initial begin
        int          p;
        int          last_redir;
        int          cyc;
        int unsigned r;
        rst = 1'b1;
        stall = 1'b0;
        mem_wait = 1'b0;
        flush = 1'b0;
        redir = 1'b0;
        redir_pc = RESET_PC;
        for (int i = 0; i < 2048; i++) prog[i] = parcel_t'(i * 40503) ^ parcel_t'(i >> 3) | 16'h3;
        p = 0;
        for (int i = 0; i < N_PROG; i++) begin
            starts[i] = p;
            r = lcg_next();
            if (i >= N_ALIGNED && r[20]) begin
                prog[p] = make_rvc(lcg_next());
                p = p + 1;
            end else begin
                prog[p]   = parcel_t'(lcg_next() >> 8) | 16'h3;
                prog[p+1] = parcel_t'(lcg_next() >> 8);
                p = p + 2;
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("mem_addr_o", mem_addr, RESET_PC);
        last_redir = 0;
        cyc = 0;
        while (delivered < N_DELIV) begin
            @(posedge clk);
            cyc++;
            redir <= 1'b0;
            flush <= 1'b0;
            if (delivered < N_ALIGNED) continue;
            r = lcg_next();
            if (cyc - last_redir > 60 &&
                (dut.u_fetch_ctrl.state_o == ALIGN_SPLIT || cyc - last_redir > 120)) begin
                redir_idx <= starts[(r >> 8) % 200];
                redir_pc  <= RESET_PC + pc_t'(starts[(r >> 8) % 200]);
                redir     <= 1'b1;
                flush     <= 1'b1;
                stall     <= 1'b0;   // redirect only counts on an unheld edge
                mem_wait  <= 1'b0;
                last_redir = cyc;
            end else begin
                stall    <= (r[19:16] < 4'd3);
                mem_wait <= (r[23:20] < 4'd3);
            end
        end
        @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

/* dv/fetch_sva.sv */
module fetch_sva import rv_fetch_pkg::*; (
    input logic         clk_i,
    input logic         rst_i,
    input logic         hold_o,
    input align_state_e state_o,
    input xlen_t        dec_instr_o,
    input pc_t          dec_pc_o,
    input pc_t          dec_pc_next_o,
    input logic         dec_valid_o
);

    valid_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !dec_valid_o)
        else $error("dec_valid_o high right after reset");

    // a held stage keeps every decode output
    outputs_stable_on_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        hold_o |=> $stable(dec_instr_o) && $stable(dec_valid_o) &&
                   $stable(dec_pc_o) && $stable(dec_pc_next_o))
        else $error("decode outputs changed while the stage was held");

    state_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        state_o inside {ALIGN_NORMAL, ALIGN_SPLIT, ALIGN_BUFFERED})
        else $error("alignment state outside its encoding");

endmodule

bind fetch_ctrl fetch_sva u_fetch_sva (.*);

/* rtl/fetch_top.sv */
module fetch_top import rv_fetch_pkg::*; #(
    parameter pc_t RESET_PC = pc_t'(32'h4000_0000 >> 1)
) (
    input  logic  clk_i,
    input  logic  rst_i,

    // instruction memory
    output pc_t   mem_addr_o,
    input  xlen_t mem_data_i,
    input  logic  mem_wait_i,

    // pipeline control
    input  logic  stall_i,
    input  logic  flush_i,

    // execute redirect
    input  logic  redirect_valid_i,
    input  pc_t   redirect_pc_i,

    // decode stage
    output xlen_t dec_instr_o,
    output pc_t   dec_pc_o,
    output pc_t   dec_pc_next_o,
    output logic  dec_valid_o
);

    pc_t          pc;
    pc_t          pc_inc;
    parcel_t      parcel;
    logic         is_compressed;
    xlen_t        split_instr;
    xlen_t        expanded;
    align_state_e state;
    logic         hold;
    logic         pc_hold;

    assign mem_addr_o = pc;  // word select is pc[30:1]

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .hold_i           (hold),
        .pc_hold_i        (pc_hold),
        .is_compressed_i  (is_compressed),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .pc_o             (pc),
        .pc_inc_o         (pc_inc)
    );

    instr_align u_instr_align (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .hold_i          (hold),
        .pc_half_i       (pc[0]),
        .state_i         (state),
        .mem_data_i      (mem_data_i),
        .parcel_o        (parcel),
        .is_compressed_o (is_compressed),
        .split_instr_o   (split_instr)
    );

    rvc_expander u_rvc_expander (
        .parcel_i   (parcel),
        .expanded_o (expanded)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .mem_wait_i       (mem_wait_i),
        .flush_i          (flush_i),
        .redirect_valid_i (redirect_valid_i),
        .pc_i             (pc),
        .pc_inc_i         (pc_inc),
        .is_compressed_i  (is_compressed),
        .expanded_i       (expanded),
        .split_instr_i    (split_instr),
        .mem_data_i       (mem_data_i),
        .hold_o           (hold),
        .pc_hold_o        (pc_hold),
        .state_o          (state),
        .dec_instr_o      (dec_instr_o),
        .dec_pc_o         (dec_pc_o),
        .dec_pc_next_o    (dec_pc_next_o),
        .dec_valid_o      (dec_valid_o)
    );

endmodule

/* rtl/fetch_ctrl.sv */
module fetch_ctrl import rv_fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         stall_i,
    input  logic         mem_wait_i,
    input  logic         flush_i,
    input  logic         redirect_valid_i,
    input  pc_t          pc_i,
    input  pc_t          pc_inc_i,
    input  logic         is_compressed_i,
    input  xlen_t        expanded_i,
    input  xlen_t        split_instr_i,
    input  xlen_t        mem_data_i,
    output logic         hold_o,
    output logic         pc_hold_o,
    output align_state_e state_o,
    output xlen_t        dec_instr_o,
    output pc_t          dec_pc_o,
    output pc_t          dec_pc_next_o,
    output logic         dec_valid_o
);

    align_state_e state_q;
    align_state_e state_d;
    xlen_t        instr_d;
    pc_t          pc_d;
    pc_t          pc_next_d;
    logic         issue_d;
    logic         upper_compressed;  // parcel in the upper half of the bus word

    assign hold_o           = stall_i | mem_wait_i;
    assign upper_compressed = (mem_data_i[17:16] != 2'b11);
    assign pc_hold_o        = (state_q == ALIGN_SPLIT) && upper_compressed;
    assign state_o          = state_q;

    always_comb begin
        state_d   = ALIGN_NORMAL;
        instr_d   = is_compressed_i ? expanded_i : mem_data_i;
        pc_d      = pc_i;
        pc_next_d = pc_inc_i;
        issue_d   = 1'b1;
        case (state_q)
            ALIGN_NORMAL: begin
                if (pc_i[0] && !is_compressed_i) begin  // 32-bit starts in upper half
                    state_d = ALIGN_SPLIT;
                    instr_d = INSTR_BUBBLE;
                    issue_d = 1'b0;
                end
            end
            ALIGN_SPLIT: begin
                instr_d   = split_instr_i;
                pc_d      = pc_i - pc_t'(2);  // pc already points past the low half
                pc_next_d = pc_i;
                state_d   = upper_compressed ? ALIGN_BUFFERED : ALIGN_SPLIT;
            end
            ALIGN_BUFFERED: instr_d = expanded_i;
            default: begin
                instr_d = INSTR_BUBBLE;
                issue_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= ALIGN_NORMAL;
            dec_instr_o   <= INSTR_BUBBLE;
            dec_pc_o      <= '0;
            dec_pc_next_o <= '0;
            dec_valid_o   <= 1'b0;
        end else if (!hold_o) begin
            state_q       <= redirect_valid_i ? ALIGN_NORMAL : state_d;
            dec_pc_o      <= pc_d;
            dec_pc_next_o <= pc_next_d;
            if (flush_i) begin  // drop the wrong-path instruction
                dec_instr_o <= INSTR_BUBBLE;
                dec_valid_o <= 1'b0;
            end else begin
                dec_instr_o <= instr_d;
                dec_valid_o <= issue_d;
            end
        end
    end

endmodule

/* rtl/pc_gen.sv */
module pc_gen import rv_fetch_pkg::*; #(
    parameter pc_t RESET_PC = pc_t'(32'h4000_0000 >> 1)
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic hold_i,
    input  logic pc_hold_i,
    input  logic is_compressed_i,
    input  logic redirect_valid_i,
    input  pc_t  redirect_pc_i,
    output pc_t  pc_o,
    output pc_t  pc_inc_o
);

    pc_t step;  // in halfwords

    assign step     = is_compressed_i ? pc_t'(1) : pc_t'(2);
    assign pc_inc_o = pc_o + step;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= RESET_PC;
        end else if (!hold_i) begin
            if (redirect_valid_i) begin
                pc_o <= redirect_pc_i;     // execute target wins
            end else if (!pc_hold_i) begin
                pc_o <= pc_inc_o;
            end
            // pc_hold_i: next parcel is already in the buffer
        end
    end

endmodule

/* rtl/instr_align.sv */
module instr_align import rv_fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         hold_i,
    input  logic         pc_half_i,
    input  align_state_e state_i,
    input  xlen_t        mem_data_i,
    output parcel_t      parcel_o,
    output logic         is_compressed_o,
    output xlen_t        split_instr_o
);

    parcel_t upper_buf;  // upper half of the last word taken

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            upper_buf <= '0;
        end else if (!hold_i) begin
            upper_buf <= mem_data_i[31:16];
        end
    end

    // In the normal state the parcel always comes from the word on the bus.
    // This keeps an odd redirect target correct, as the buffer may hold a
    // half from the old path.
    always_comb begin
        if (state_i == ALIGN_NORMAL) begin
            parcel_o = pc_half_i ? mem_data_i[31:16] : mem_data_i[15:0];
        end else begin
            parcel_o = upper_buf;  // split or buffered
        end
    end

    assign is_compressed_o = (parcel_o[1:0] != 2'b11);

    // high half of a straddling instruction sits in the low half of this word
    assign split_instr_o = {mem_data_i[15:0], upper_buf};

endmodule

/* rtl/rvc_expander.sv */
module rvc_expander import rv_fetch_pkg::*; (
    input  parcel_t parcel_i,
    output xlen_t   expanded_o
);

    parcel_t    c;
    logic [4:0] rd;     // rd/rs1 field, bits 11:7
    logic [4:0] rs2;    // rs2 field, bits 6:2
    logic [4:0] rdc;    // rd'/rs1' mapped to x8..x15
    logic [4:0] rs2c;   // rs2'/rd' mapped to x8..x15

    assign c    = parcel_i;
    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    assign rdc  = {2'b01, c[9:7]};
    assign rs2c = {2'b01, c[4:2]};

    always_comb begin
        expanded_o = INSTR_BUBBLE;  // unsupported encodings
        case ({c[15:13], c[1:0]})
            5'b000_00: begin  // c.addi4spn, all-zero parcel is illegal
                if (c[12:5] != 8'd0) begin
                    expanded_o = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                  5'd2, 3'b000, rs2c, OPC_OP_IMM};
                end
            end
            5'b010_00: expanded_o = {5'b0, c[5], c[12:10], c[6], 2'b00,
                                     rdc, 3'b010, rs2c, OPC_LOAD};           // c.lw
            5'b110_00: expanded_o = {5'b0, c[5], c[12], rs2c, rdc, 3'b010,
                                     c[11:10], c[6], 2'b00, OPC_STORE};      // c.sw
            5'b000_01: expanded_o = {{7{c[12]}}, rs2, rd, 3'b000, rd, OPC_OP_IMM}; // c.nop, c.addi
            5'b001_01,
            5'b101_01: begin
                // c.jal links x1, c.j links x0
                expanded_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                              {9{c[12]}}, 4'b0000, ~c[15], OPC_JAL};
            end
            5'b010_01: expanded_o = {{7{c[12]}}, rs2, 5'd0, 3'b000, rd, OPC_OP_IMM}; // c.li
            5'b011_01: begin
                if (rd == 5'd2) begin  // c.addi16sp
                    expanded_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                                  5'd2, 3'b000, 5'd2, OPC_OP_IMM};
                end else begin         // c.lui
                    expanded_o = {{15{c[12]}}, rs2, rd, OPC_LUI};
                end
            end
            5'b100_01: begin
                case (c[11:10])
                    2'b00: expanded_o = {7'b000_0000, rs2, rdc, 3'b101, rdc, OPC_OP_IMM}; // srli
                    2'b01: expanded_o = {7'b010_0000, rs2, rdc, 3'b101, rdc, OPC_OP_IMM}; // srai
                    2'b10: expanded_o = {{7{c[12]}}, rs2, rdc, 3'b111, rdc, OPC_OP_IMM};  // andi
                    default: begin
                        if (!c[12]) begin  // c[12] set is rv64 only
                            case (c[6:5])
                                2'b00: expanded_o = {7'b010_0000, rs2c, rdc, 3'b000, rdc, OPC_OP};
                                2'b01: expanded_o = {7'b000_0000, rs2c, rdc, 3'b100, rdc, OPC_OP};
                                2'b10: expanded_o = {7'b000_0000, rs2c, rdc, 3'b110, rdc, OPC_OP};
                                default: expanded_o = {7'b000_0000, rs2c, rdc, 3'b111, rdc, OPC_OP};
                            endcase
                        end
                    end
                endcase
            end
            5'b110_01,
            5'b111_01: begin
                // c.beqz / c.bnez, funct3 bit 0 comes from c[13]
                expanded_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, rdc, 2'b00, c[13],
                              c[11:10], c[4:3], c[12], OPC_BRANCH};
            end
            5'b000_10: expanded_o = {7'b000_0000, rs2, rd, 3'b001, rd, OPC_OP_IMM}; // c.slli
            5'b010_10: expanded_o = {4'b0000, c[3:2], c[12], c[6:4], 2'b00,
                                     5'd2, 3'b010, rd, OPC_LOAD};            // c.lwsp
            5'b100_10: begin
                if (!c[12]) begin
                    if (rs2 == 5'd0) begin
                        expanded_o = {12'd0, rd, 3'b000, 5'd0, OPC_JALR};    // c.jr
                    end else begin
                        expanded_o = {7'b000_0000, rs2, 5'd0, 3'b000, rd, OPC_OP}; // c.mv
                    end
                end else if (rs2 == 5'd0) begin
                    if (rd != 5'd0) begin  // rd zero is c.ebreak, the default
                        expanded_o = {12'd0, rd, 3'b000, 5'd1, OPC_JALR};    // c.jalr
                    end
                end else begin
                    expanded_o = {7'b000_0000, rs2, rd, 3'b000, rd, OPC_OP}; // c.add
                end
            end
            5'b110_10: expanded_o = {4'b0000, c[8:7], c[12], rs2, 5'd2, 3'b010,
                                     c[11:9], 2'b00, OPC_STORE};             // c.swsp
            default: expanded_o = INSTR_BUBBLE;
        endcase
    end

endmodule

/* rtl/rv_fetch_pkg.sv */
package rv_fetch_pkg;

    localparam int XLEN     = 32;
    localparam int PARCEL_W = 16;
    localparam int PC_W     = XLEN - 1;   // halfword address, byte bit 0 is dropped

    typedef logic [XLEN-1:0]     xlen_t;    // instruction or memory word
    typedef logic [PARCEL_W-1:0] parcel_t;  // one 16-bit half of a word
    typedef logic [PC_W-1:0]     pc_t;      // halfword program counter

    // where the next instruction comes from
    typedef enum logic [1:0] {
        ALIGN_NORMAL   = 2'd0,  // next instruction starts in the current word
        ALIGN_SPLIT    = 2'd1,  // low half of a straddling instruction is buffered
        ALIGN_BUFFERED = 2'd2   // compressed parcel served from the buffer
    } align_state_e;

    // base opcodes produced by the compressed expansion
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    // ebreak, harmless filler for reset, flush and unsupported parcels
    localparam xlen_t INSTR_BUBBLE = 32'h0010_0073;

endpackage
